/* rtl/hisPkg.sv */
`default_nettype none

package hisPkg;

    // acquisition FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ACQ  = 2'd1,
        SCAN = 2'd2,
        DONE = 2'd3
    } acqState_e;

    // control register opcodes, code 3 is unused
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_START = 2'd1,
        OP_ABORT = 2'd2
    } hisOp_e;

    localparam int wbAddrW = 10;  // word address
    localparam int wbDataW = 32;

    // register map
    localparam logic [wbAddrW-1:0] regCtrl      = 10'd0;  // wr opcode, rd status
    localparam logic [wbAddrW-1:0] regOffset    = 10'd1;
    localparam logic [wbAddrW-1:0] regFrameLen  = 10'd2;
    localparam logic [wbAddrW-1:0] regDiscard   = 10'd3;  // read only
    localparam logic [wbAddrW-1:0] regPeakCount = 10'd4;  // read only

    // bin n sits at binBase + n
    localparam logic [wbAddrW-1:0] binBase = 10'd256;

endpackage

`default_nettype wire

/* rtl/acqControl.sv */
`timescale 1ns/100ps
`default_nettype none

module acqControl #(
    parameter int numBins  = 64,
    parameter int countW   = 16,
    parameter int timeW    = 12,
    parameter int binShift = 2
) (
    input  wire logic                        clk,
    input  wire logic                        res,
    input  wire logic                        wbCyc,
    input  wire logic                        wbStb,
    input  wire logic                        wbWe,
    input  wire logic [hisPkg::wbAddrW-1:0]  wbAddr,
    input  wire logic [hisPkg::wbDataW-1:0]  wbDatW,
    output logic      [hisPkg::wbDataW-1:0]  wbDatR,
    output logic                             wbAck,
    input  wire logic                        evValid,
    input  wire logic [timeW-1:0]            evTime,
    output logic                             binValid,
    output logic      [$clog2(numBins)-1:0]  binIdx,
    output logic                             clearAll,
    output logic                             rdReq,
    output logic      [$clog2(numBins)-1:0]  rdIdx,
    input  wire logic [countW-1:0]           rdCount,
    input  wire logic                        scanReq,
    input  wire logic [$clog2(numBins)-1:0]  scanIdx,
    input  wire logic                        scanDone,
    input  wire logic [$clog2(numBins)-1:0]  peakIdx,
    input  wire logic [countW-1:0]           peakCount,
    output hisPkg::acqState_e                acqState,
    output logic                             frameDone
);

    localparam int idxW = $clog2(numBins);

    logic                       accept;
    logic                       isBin;
    logic                       ctrlWr;
    hisPkg::hisOp_e             cmdOp;
    logic [hisPkg::wbDataW-1:0] statusWord;
    logic [hisPkg::wbDataW-1:0] regMux;
    logic [hisPkg::wbDataW-1:0] regDat;
    logic                       binSel;     // ack carries a bin count
    logic                       busRdPend;  // bin read waiting for the port
    logic [idxW-1:0]            busRdIdx;
    logic [timeW-1:0]           offset;
    logic [hisPkg::wbDataW-1:0] frameLen;
    logic [hisPkg::wbDataW-1:0] evCount;
    logic [hisPkg::wbDataW-1:0] discardCnt;
    logic [timeW-1:0]           evDelta;
    logic [timeW-1:0]           evBin;
    logic                       evInRange;

    // one transfer at a time, the ack cycle itself is not a new request
    assign accept = wbCyc && wbStb && !wbAck && !busRdPend;
    assign isBin  = (wbAddr >= hisPkg::binBase) && (wbAddr < hisPkg::binBase + numBins);
    assign ctrlWr = accept && wbWe && (wbAddr == hisPkg::regCtrl);
    assign cmdOp  = hisPkg::hisOp_e'(wbDatW[1:0]);

    // code to bin, codes below the offset wrap and are caught by the compare
    assign evDelta   = evTime - offset;
    assign evBin     = evDelta >> binShift;
    assign evInRange = (evTime >= offset) && (evBin < numBins);

    always_comb begin
        statusWord       = '0;
        statusWord[1:0]  = acqState;
        statusWord[15:8] = 8'(peakIdx);
    end

    always_comb begin
        case (wbAddr)
            hisPkg::regCtrl:      regMux = statusWord;
            hisPkg::regOffset:    regMux = hisPkg::wbDataW'(offset);
            hisPkg::regFrameLen:  regMux = frameLen;
            hisPkg::regDiscard:   regMux = discardCnt;
            hisPkg::regPeakCount: regMux = hisPkg::wbDataW'(peakCount);
            default:              regMux = '0;
        endcase
    end

    // scanner owns the read port during SCAN
    assign rdReq = (acqState == hisPkg::SCAN) ? scanReq : busRdPend;
    assign rdIdx = (acqState == hisPkg::SCAN) ? scanIdx : busRdIdx;

    assign wbDatR    = binSel ? hisPkg::wbDataW'(rdCount) : regDat;
    assign frameDone = (acqState == hisPkg::DONE);

    // bus side
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wbAck     <= 1'b0;
            binSel    <= 1'b0;
            busRdPend <= 1'b0;
            offset    <= '0;
            frameLen  <= '0;
        end else begin
            wbAck <= 1'b0;
            if (accept) begin
                if (isBin && !wbWe) begin
                    busRdPend <= 1'b1;
                end else begin
                    wbAck  <= 1'b1;  // registers and ignored bin writes
                    binSel <= 1'b0;
                    if (wbWe && wbAddr == hisPkg::regOffset)
                        offset <= wbDatW[timeW-1:0];
                    if (wbWe && wbAddr == hisPkg::regFrameLen)
                        frameLen <= wbDatW;
                end
            end
            // read goes out this cycle, count is back for the ack
            if (busRdPend && acqState != hisPkg::SCAN) begin
                busRdPend <= 1'b0;
                wbAck     <= 1'b1;
                binSel    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            regDat   <= regMux;
            busRdIdx <= idxW'(wbAddr - hisPkg::binBase);
        end
    end

    // acquisition FSM and event counting
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqState   <= hisPkg::IDLE;
            evCount    <= '0;
            discardCnt <= '0;
            binValid   <= 1'b0;
            clearAll   <= 1'b0;
        end else begin
            binValid <= 1'b0;
            clearAll <= 1'b0;
            if (ctrlWr && cmdOp == hisPkg::OP_START) begin
                acqState   <= hisPkg::ACQ;
                evCount    <= '0;
                discardCnt <= '0;
                clearAll   <= 1'b1;
            end else if (ctrlWr && cmdOp == hisPkg::OP_ABORT) begin
                acqState <= hisPkg::IDLE;
            end else begin
                case (acqState)
                    hisPkg::ACQ: begin
                        if (evValid) begin
                            evCount  <= evCount + 1'b1;
                            binValid <= evInRange;
                            if (!evInRange)
                                discardCnt <= discardCnt + 1'b1;
                            if (evCount + 1'b1 >= frameLen)
                                acqState <= hisPkg::SCAN;  // frame full
                        end
                    end
                    hisPkg::SCAN: if (scanDone) acqState <= hisPkg::DONE;
                    default: ;  // IDLE and DONE wait for a command
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (evValid)
            binIdx <= evBin[idxW-1:0];
    end

endmodule

`default_nettype wire

/* rtl/hisMemory.sv */
`timescale 1ns/100ps
`default_nettype none

module hisMemory #(
    parameter int numBins = 64,
    parameter int countW  = 16
) (
    input  wire logic                       clk,
    input  wire logic                       res,
    input  wire logic                       binValid,
    input  wire logic [$clog2(numBins)-1:0] binIdx,
    input  wire logic                       clearAll,
    input  wire logic                       rdReq,
    input  wire logic [$clog2(numBins)-1:0] rdIdx,
    output logic      [countW-1:0]          rdCount
);

    localparam int idxW = $clog2(numBins);
    localparam logic [countW-1:0] countMax = {countW{1'b1}};

    logic [countW-1:0] mem [numBins];
    logic [numBins-1:0] validBits;  // clear bit means bin reads as zero

    // stage 1, bin already read
    logic              s1Valid;
    logic [idxW-1:0]   s1Idx;
    logic [countW-1:0] s1Count;
    logic              s1Hit;

    logic [countW-1:0] s1Base;
    logic [countW-1:0] s1Sum;
    logic              fwdEv;
    logic              fwdRd;

    assign s1Base = s1Hit ? s1Count : '0;
    assign s1Sum  = (s1Base == countMax) ? s1Base : s1Base + 1'b1;  // saturate

    // same bin as the write in flight, take the new value
    assign fwdEv = s1Valid && (s1Idx == binIdx);
    assign fwdRd = s1Valid && (s1Idx == rdIdx);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            validBits <= '0;
            s1Valid   <= 1'b0;
        end else begin
            s1Valid <= binValid;
            if (s1Valid)
                validBits[s1Idx] <= 1'b1;
            if (clearAll)
                validBits <= '0;  // lazy clear of the whole histogram
        end
    end

    always_ff @(posedge clk) begin
        if (binValid) begin
            s1Idx   <= binIdx;
            s1Count <= fwdEv ? s1Sum : mem[binIdx];
            s1Hit   <= fwdEv || validBits[binIdx];
        end
        if (s1Valid)
            mem[s1Idx] <= s1Sum;  // write back
    end

    // shared read port, one cycle latency
    always_ff @(posedge clk) begin
        if (rdReq) begin
            if (fwdRd)
                rdCount <= s1Sum;
            else if (validBits[rdIdx])
                rdCount <= mem[rdIdx];
            else
                rdCount <= '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/peakSearch.sv */
`timescale 1ns/100ps
`default_nettype none

module peakSearch #(
    parameter int numBins = 64,
    parameter int countW  = 16
) (
    input  wire logic                       clk,
    input  wire logic                       res,
    input  wire hisPkg::acqState_e          acqState,
    input  wire logic [countW-1:0]          rdCount,
    output logic                            scanReq,
    output logic      [$clog2(numBins)-1:0] scanIdx,
    output logic                            scanDone,
    output logic      [$clog2(numBins)-1:0] peakIdx,
    output logic      [countW-1:0]          peakCount
);

    localparam int idxW = $clog2(numBins);
    localparam logic [idxW-1:0] lastIdx = idxW'(numBins - 1);

    logic            armed;     // ready for the next SCAN entry
    logic            cmpValid;  // rdCount holds a scanned bin
    logic [idxW-1:0] cmpIdx;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            armed     <= 1'b1;
            scanReq   <= 1'b0;
            scanIdx   <= '0;
            cmpValid  <= 1'b0;
            scanDone  <= 1'b0;
            peakIdx   <= '0;
            peakCount <= '0;
        end else begin
            scanDone <= 1'b0;
            cmpValid <= scanReq;
            if (acqState != hisPkg::SCAN) begin
                armed   <= 1'b1;
                scanReq <= 1'b0;
            end else if (armed) begin
                armed     <= 1'b0;
                scanReq   <= 1'b1;
                scanIdx   <= '0;
                peakIdx   <= '0;
                peakCount <= '0;
            end else if (scanReq) begin
                if (scanIdx == lastIdx)
                    scanReq <= 1'b0;
                else
                    scanIdx <= scanIdx + 1'b1;
            end
            // strictly greater, so a tie keeps the lower index
            if (cmpValid && rdCount > peakCount) begin
                peakCount <= rdCount;
                peakIdx   <= cmpIdx;
            end
            if (cmpValid && cmpIdx == lastIdx)
                scanDone <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        cmpIdx <= scanIdx;  // follows the read latency
    end

endmodule

`default_nettype wire

/* rtl/hisBuilder.sv */
`timescale 1ns/100ps
`default_nettype none

module hisBuilder #(
    parameter int numBins  = 64,
    parameter int countW   = 16,
    parameter int timeW    = 12,
    parameter int binShift = 2
) (
    input  wire logic                       clk,
    input  wire logic                       res,
    input  wire logic                       wbCyc,
    input  wire logic                       wbStb,
    input  wire logic                       wbWe,
    input  wire logic [hisPkg::wbAddrW-1:0] wbAddr,
    input  wire logic [hisPkg::wbDataW-1:0] wbDatW,
    output logic      [hisPkg::wbDataW-1:0] wbDatR,
    output logic                            wbAck,
    input  wire logic                       evValid,
    input  wire logic [timeW-1:0]           evTime,
    output logic                            frameDone
);

    localparam int idxW = $clog2(numBins);

    // event path
    logic              binValid;
    logic [idxW-1:0]   binIdx;
    logic              clearAll;
    // shared read port
    logic              rdReq;
    logic [idxW-1:0]   rdIdx;
    logic [countW-1:0] rdCount;
    // scanner
    logic              scanReq;
    logic [idxW-1:0]   scanIdx;
    logic              scanDone;
    logic [idxW-1:0]   peakIdx;
    logic [countW-1:0] peakCount;
    hisPkg::acqState_e acqState;

    acqControl #(
        .numBins  (numBins),
        .countW   (countW),
        .timeW    (timeW),
        .binShift (binShift)
    ) acqControl_i (
        .clk       (clk),
        .res       (res),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAddr    (wbAddr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .evValid   (evValid),
        .evTime    (evTime),
        .binValid  (binValid),
        .binIdx    (binIdx),
        .clearAll  (clearAll),
        .rdReq     (rdReq),
        .rdIdx     (rdIdx),
        .rdCount   (rdCount),
        .scanReq   (scanReq),
        .scanIdx   (scanIdx),
        .scanDone  (scanDone),
        .peakIdx   (peakIdx),
        .peakCount (peakCount),
        .acqState  (acqState),
        .frameDone (frameDone)
    );

    hisMemory #(
        .numBins (numBins),
        .countW  (countW)
    ) hisMemory_i (
        .clk      (clk),
        .res      (res),
        .binValid (binValid),
        .binIdx   (binIdx),
        .clearAll (clearAll),
        .rdReq    (rdReq),
        .rdIdx    (rdIdx),
        .rdCount  (rdCount)
    );

    peakSearch #(
        .numBins (numBins),
        .countW  (countW)
    ) peakSearch_i (
        .clk       (clk),
        .res       (res),
        .acqState  (acqState),
        .rdCount   (rdCount),
        .scanReq   (scanReq),
        .scanIdx   (scanIdx),
        .scanDone  (scanDone),
        .peakIdx   (peakIdx),
        .peakCount (peakCount)
    );

endmodule

`default_nettype wire

/* tests/hisBuilderTb.sv */
`timescale 1ns/100ps
`default_nettype none

module hisBuilderTb;

    localparam int numBins    = 64;
    localparam int countW     = 4;  // small, so a bin saturates quickly
    localparam int timeW      = 12;
    localparam int binShift   = 2;
    localparam int countMax   = (1 << countW) - 1;
    localparam int ackLimit   = 200;  // a bin read may be held through a whole scan
    localparam int frameLimit = 2000;

    logic                       clk;
    logic                       res;
    logic                       wbCyc;
    logic                       wbStb;
    logic                       wbWe;
    logic [hisPkg::wbAddrW-1:0] wbAddr;
    logic [hisPkg::wbDataW-1:0] wbDatW;
    logic [hisPkg::wbDataW-1:0] wbDatR;
    logic                       wbAck;
    logic                       evValid;
    logic [timeW-1:0]           evTime;
    logic                       frameDone;

    // reference histogram
    int          binCnt [numBins];
    logic [31:0] refOffset;
    logic [31:0] refFrameLen;
    logic [31:0] refEvCount;
    logic [31:0] refDiscard;
    logic        refAcq;
    int          refPeakIdx;  // snapshot of the last completed frame
    int          refPeakCnt;

    logic [31:0] rng;
    int          fd;
    int          i;
    logic [7:0]  op;
    logic [31:0] argA;
    logic [31:0] argB;
    logic [31:0] rdWord;

    hisBuilder #(
        .numBins  (numBins),
        .countW   (countW),
        .timeW    (timeW),
        .binShift (binShift)
    ) dut_i (
        .clk       (clk),
        .res       (res),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAddr    (wbAddr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .evValid   (evValid),
        .evTime    (evTime),
        .frameDone (frameDone)
    );

    always #20 clk = ~clk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [hisPkg::wbDataW-1:0] got,
                             input logic [hisPkg::wbDataW-1:0] exp);
        if (got !== exp)
            stopRun($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic checkState(input hisPkg::acqState_e got, input hisPkg::acqState_e exp);
        if (got !== exp)
            stopRun($sformatf("ERROR acqState: got %h, expected %h", got, exp));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopRun($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void findPeak();
        refPeakIdx = 0;
        refPeakCnt = 0;
        for (int b = 0; b < numBins; b++) begin
            if (binCnt[b] > refPeakCnt) begin  // strictly greater, lowest index keeps a tie
                refPeakCnt = binCnt[b];
                refPeakIdx = b;
            end
        end
    endfunction

    function automatic void applyEvent(input logic [timeW-1:0] code);
        int delta;
        delta = int'(code) - int'(refOffset);
        if (refAcq) begin
            refEvCount++;
            if (delta < 0 || (delta >> binShift) >= numBins)
                refDiscard++;
            else if (binCnt[delta >> binShift] < countMax)
                binCnt[delta >> binShift]++;
            if (refEvCount >= refFrameLen) begin
                refAcq = 1'b0;  // frame full, later events ignored
                findPeak();
            end
        end
    endfunction

    function automatic void applyWrite(input logic [hisPkg::wbAddrW-1:0] addr,
                                       input logic [hisPkg::wbDataW-1:0] data);
        if (addr == hisPkg::regOffset)
            refOffset = 32'(data[timeW-1:0]);
        if (addr == hisPkg::regFrameLen)
            refFrameLen = data;
        if (addr == hisPkg::regCtrl && hisPkg::hisOp_e'(data[1:0]) == hisPkg::OP_START) begin
            for (int b = 0; b < numBins; b++)
                binCnt[b] = 0;
            refDiscard = 0;
            refEvCount = 0;
            refAcq     = 1'b1;
        end
        if (addr == hisPkg::regCtrl && hisPkg::hisOp_e'(data[1:0]) == hisPkg::OP_ABORT)
            refAcq = 1'b0;
    endfunction

    // starts and ends 2 ns after a rising edge
    task automatic busAccess(input logic we, input logic [hisPkg::wbAddrW-1:0] addr,
                             input logic [hisPkg::wbDataW-1:0] data,
                             output logic [hisPkg::wbDataW-1:0] rdata);
        int t;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAddr = addr;
        wbDatW = data;
        @(posedge clk);
        #2;
        t = 1;
        while (!wbAck) begin
            if (t >= ackLimit)
                stopRun($sformatf("no Wishbone ack within %0d cycles, address %h", t, addr));
            @(posedge clk);
            #2;
            t++;
        end
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic busWrite(input logic [hisPkg::wbAddrW-1:0] addr,
                            input logic [hisPkg::wbDataW-1:0] data);
        logic [hisPkg::wbDataW-1:0] unused;
        busAccess(1'b1, addr, data, unused);
        applyWrite(addr, data);
    endtask

    task automatic busRead(input logic [hisPkg::wbAddrW-1:0] addr,
                           output logic [hisPkg::wbDataW-1:0] data);
        busAccess(1'b0, addr, '0, data);
    endtask

    task automatic driveEvent(input logic [timeW-1:0] code);
        evValid = 1'b1;
        evTime  = code;
        applyEvent(code);
        @(posedge clk);
        #2;
        evValid = 1'b0;
    endtask

    task automatic waitFrameDone();
        int t;
        t = 0;
        while (!frameDone) begin
            if (t >= frameLimit)
                stopRun($sformatf("frameDone did not rise within %0d cycles", t));
            @(posedge clk);
            #2;
            t++;
        end
    endtask

    task automatic checkStatus(input hisPkg::acqState_e exp);
        logic [hisPkg::wbDataW-1:0] word;
        busRead(hisPkg::regCtrl, word);
        checkState(hisPkg::acqState_e'(word[1:0]), exp);
        checkFlag("frameDone", frameDone, exp == hisPkg::DONE);
    endtask

    task automatic checkModel();
        logic [hisPkg::wbDataW-1:0] word;
        int b;
        for (b = 0; b < numBins; b++) begin
            busRead(hisPkg::wbAddrW'(hisPkg::binBase + b), word);
            checkWord($sformatf("bin %0d", b), word, binCnt[b]);
        end
        busRead(hisPkg::regDiscard, word);
        checkWord("regDiscard", word, refDiscard);
        busRead(hisPkg::regPeakCount, word);
        checkWord("regPeakCount", word, refPeakCnt);
        busRead(hisPkg::regCtrl, word);
        checkWord("status peak field", {24'b0, word[15:8]}, refPeakIdx);
    endtask

    // issued while SCAN runs, ack must wait for DONE
    task automatic readDuringScan(input int bin);
        logic [hisPkg::wbDataW-1:0] word;
        checkFlag("frameDone before scan read", frameDone, 1'b0);
        busRead(hisPkg::wbAddrW'(hisPkg::binBase + bin), word);
        checkFlag("frameDone at scan read ack", frameDone, 1'b1);
        checkWord($sformatf("bin %0d read during scan", bin), word, binCnt[bin]);
    endtask

    task automatic skipLine();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1)
            c = $fgetc(fd);
    endtask

    initial begin
        clk         = 1'b0;
        res         = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAddr      = '0;
        wbDatW      = '0;
        evValid     = 1'b0;
        evTime      = '0;
        rng         = 32'h5f30;
        refOffset   = 0;
        refFrameLen = 0;
        refEvCount  = 0;
        refDiscard  = 0;
        refAcq      = 1'b0;
        refPeakIdx  = 0;
        refPeakCnt  = 0;
        for (i = 0; i < numBins; i++)
            binCnt[i] = 0;
        fd = $fopen("tests/hisBuilder_tests.txt", "r");
        if (fd == 0)
            stopRun("cannot open tests/hisBuilder_tests.txt");
        repeat (8) @(posedge clk);
        #2;
        res = 1'b1;

        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "W": begin
                    if ($fscanf(fd, "%h %h", argA, argB) != 2)
                        stopRun("a write line in the stimulus file lacks values");
                    busWrite(hisPkg::wbAddrW'(argA), argB);
                end
                "R": begin
                    if ($fscanf(fd, "%h %h", argA, argB) != 2)
                        stopRun("a read line in the stimulus file lacks values");
                    busRead(hisPkg::wbAddrW'(argA), rdWord);
                    checkWord($sformatf("wbDatR at %h", argA[9:0]), rdWord, argB);
                end
                "S": begin
                    if ($fscanf(fd, "%h", argA) != 1)
                        stopRun("a status line in the stimulus file lacks its state");
                    checkStatus(hisPkg::acqState_e'(argA[1:0]));
                end
                "E": begin
                    if ($fscanf(fd, "%h %h", argA, argB) != 2)
                        stopRun("an event line in the stimulus file lacks values");
                    repeat (argB) driveEvent(timeW'(argA));  // back to back
                end
                "G": begin
                    if ($fscanf(fd, "%h", argA) != 1)
                        stopRun("a generate line in the stimulus file lacks its count");
                    repeat (argA) begin
                        rng = nextRandom(rng);
                        driveEvent(timeW'(rng[8:0]));  // spans both sides of the bin range
                    end
                end
                "P": begin
                    if ($fscanf(fd, "%h", argA) != 1)
                        stopRun("a scan read line in the stimulus file lacks its bin");
                    readDuringScan(int'(argA));
                end
                "F": waitFrameDone();
                "M": checkModel();
                "#": ;
                default: stopRun($sformatf("unknown command %c in the stimulus file", op));
            endcase
            skipLine();
        end
        $fclose(fd);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hisBuilder.f */
rtl/hisPkg.sv
rtl/acqControl.sv
rtl/hisMemory.sv
rtl/peakSearch.sv
rtl/hisBuilder.sv
tests/hisBuilderTb.sv

/* tests/hisBuilder_tests.txt */
# columns, hex: W addr data | R addr expected | S state | E code repeat | G count
# F waits for frameDone, M checks all bins against the model, P reads a bin during SCAN
S 0
M
W 001 00000040   offset
R 001 00000040
W 002 0000000a   ten events per frame
W 000 00000001   start
S 1
E 030 1          below offset
E 048 3          bin 2 back to back
E 13c 1          bin 63
E 140 1          just past the last bin
E 0b0 3          bin 28 ties bin 2
E 04c 1          bin 3 ends the frame
F
R 102 00000003
R 11c 00000003
R 13f 00000001
R 103 00000001
R 003 00000002
R 004 00000003
R 000 00000203
M
W 002 0000012c   random frame of 300 events
W 000 00000001
G 140
F
S 3
M
W 000 00000001   restart, old counts must vanish
M
W 002 00000040
G 48
P 05
F
M
W 002 00000100
W 000 00000001
E 060 14         bin 8 twenty times
R 108 0000000f
W 000 00000002   abort
S 0
E 060 5
G 20
M
